// ==== rtl/rom_check_pkg.sv ====
// ####################
// Shared types for the ROM integrity checker
// Digest words, multi-bit booleans, comparator FSM encoding
// and the per-region result bundle
// Import with a wildcard in the module header
// ####################

package rom_check_pkg;

  // Width of one digest word
  localparam int unsigned WordW = 32;

  typedef logic [WordW-1:0] word_t;

  // Multi-bit boolean, only two patterns are legal
  localparam int unsigned MuBi4W = 4;

  typedef logic [MuBi4W-1:0] mubi4_t;

  localparam mubi4_t MuBi4True  = 4'h6;
  localparam mubi4_t MuBi4False = 4'h9;

  // Sparse comparator encoding
  // Pairwise Hamming distance of at least 3
  typedef enum logic [4:0] {
    Waiting  = 5'b00100,
    Checking = 5'b10010,
    Done     = 5'b11001
  } cmp_state_e;

  // Status of one region as seen by the collector
  typedef struct packed {
    logic done;
    logic match;
    logic alert;
  } lane_result_t;

  // Map a plain flag onto the multi-bit encoding
  function automatic mubi4_t mubi4_from_bool(logic flag);
    mubi4_t res;
    res = flag ? MuBi4True : MuBi4False;
    return res;
  endfunction

endpackage

// ==== rtl/rom_check_dispatch.sv ====
// ####################
// Request dispatcher of the ROM checker
// Turns the rising edge of a four-phase request
// into a single start pulse for all region comparators
// ####################

module rom_check_dispatch (
  input  logic clk_i,
  input  logic rst_ni,

  // Four-phase request from the requester
  input  logic req_i,

  // One-cycle pulse, fanned out to every comparator
  output logic start_o
);

  // Request level seen on the previous edge
  logic req_q;

  // Registered start pulse
  logic start_q;
  logic start_d;

  // New request only on a low to high transition
  // Repeated requests are passed on on purpose
  // so the comparators can flag a start out of order
  assign start_d = req_i & ~req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  // Pulse is high for the cycle after the edge
  // that first samples the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start_d;
    end
  end

  assign start_o = start_q;

endmodule

// ==== rtl/rom_check_compare.sv ====
// ####################
// Per-region digest comparator
// Walks the computed and expected digest one word per cycle
// after a start pulse and parks in Done
// Reports done, match and a consistency alert to the collector
// ####################

module rom_check_compare
  import rom_check_pkg::*;
#(
  parameter int unsigned NumWords = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      start_i,

  // Word 0 sits at the least significant bits
  input  logic [NumWords*WordW-1:0] digest_i,
  input  logic [NumWords*WordW-1:0] exp_digest_i,

  output lane_result_t              result_o
);

  localparam int unsigned AddrW = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam logic [AddrW-1:0] LastAddr = AddrW'(NumWords - 1);

  cmp_state_e state_q, state_d;

  // Plain address register, guarded by the consistency checks below
  logic [AddrW-1:0] addr_q, addr_d;

  // Sticky equality flag
  logic match_q, match_d;

  // Currently addressed word pair
  word_t digest_word;
  word_t exp_word;

  logic fsm_alert;
  logic start_alert;
  logic wait_addr_alert;
  logic done_addr_alert;

  assign digest_word = digest_i[addr_q*WordW +: WordW];
  assign exp_word    = exp_digest_i[addr_q*WordW +: WordW];

  always_comb begin
    state_d   = state_q;
    addr_d    = addr_q;
    match_d   = match_q;
    fsm_alert = 1'b0;
    case (state_q)
      Waiting: begin
        if (start_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        // Fold in the word pair of this cycle
        match_d = match_q & (digest_word == exp_word);
        if (addr_q == LastAddr) begin
          state_d = Done;
        end else begin
          addr_d = addr_q + 1'b1;
        end
      end
      Done: begin
        // Terminal, left only through reset
      end
      default: begin
        fsm_alert = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Waiting;
      addr_q  <= '0;
      match_q <= 1'b1;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      match_q <= match_d;
    end
  end

  // Start is only legal while idle
  assign start_alert = start_i & (state_q != Waiting);

  // Address must rest at 0 before and at the last word after the walk
  assign wait_addr_alert = (state_q == Waiting) & (addr_q != '0);
  assign done_addr_alert = (state_q == Done) & (addr_q != LastAddr);

  assign result_o.done  = (state_q == Done);
  assign result_o.match = match_q;
  assign result_o.alert = fsm_alert | start_alert | wait_addr_alert | done_addr_alert;

endmodule

// ==== rtl/rom_check_collect.sv ====
// ####################
// Result collector of the ROM checker
// Waits until every region is done, latches the verdict
// and the fail map, and completes the four-phase handshake
// Also gathers the consistency alerts of all regions
// ####################

module rom_check_collect
  import rom_check_pkg::*;
#(
  parameter int unsigned NumRegions = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             req_i,
  input  lane_result_t [NumRegions-1:0]    results_i,

  output logic                             ack_o,
  output mubi4_t                           good_o,
  output logic         [NumRegions-1:0]    fail_map_o,
  output logic                             alert_o
);

  logic all_done;
  logic all_match;
  logic any_alert;
  logic [NumRegions-1:0] fail_d;

  logic ack_q;
  mubi4_t good_q;
  logic [NumRegions-1:0] fail_q;
  logic alert_q;

  // Reduce the region results
  always_comb begin
    all_done  = 1'b1;
    all_match = 1'b1;
    any_alert = 1'b0;
    fail_d    = '0;
    for (int unsigned r = 0; r < NumRegions; r++) begin
      all_done  = all_done & results_i[r].done;
      all_match = all_match & results_i[r].match;
      any_alert = any_alert | results_i[r].alert;
      fail_d[r] = ~results_i[r].match;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      good_q  <= MuBi4False;
      fail_q  <= '0;
      alert_q <= 1'b0;
    end else begin
      // Open request and every region finished
      if (!ack_q && req_i && all_done) begin
        ack_q  <= 1'b1;
        fail_q <= fail_d;
        good_q <= mubi4_from_bool(all_match);
      end else if (ack_q && !req_i) begin
        // Requester withdrew, close the handshake
        ack_q <= 1'b0;
      end
      // Once raised, stays until reset
      alert_q <= alert_q | any_alert;
    end
  end

  assign ack_o      = ack_q;
  assign good_o     = good_q;
  assign fail_map_o = fail_q;
  assign alert_o    = alert_q;

endmodule

// ==== rtl/rom_check_top.sv ====
// ####################
// Top level of the ROM integrity checker
// Dispatcher, one comparator per region, and the collector
// Digest buses carry region 0, word 0 at the low bits
// ####################

module rom_check_top
  import rom_check_pkg::*;
#(
  parameter int unsigned NumRegions = 4,
  parameter int unsigned NumWords   = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Four-phase handshake
  input  logic                                 req_i,
  output logic                                 ack_o,

  // Computed and expected digests, stable while the check runs
  input  logic [NumRegions*NumWords*WordW-1:0] digest_i,
  input  logic [NumRegions*NumWords*WordW-1:0] exp_digest_i,

  output mubi4_t                               good_o,
  output logic [NumRegions-1:0]                fail_map_o,
  output logic                                 alert_o
);

  // Bits per region slice
  localparam int unsigned RegionW = NumWords * WordW;

  logic start;
  lane_result_t [NumRegions-1:0] results;

  rom_check_dispatch i_dispatch (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .start_o (start)
  );

  // One comparator per region
  for (genvar r = 0; r < NumRegions; r++) begin : gen_region
    rom_check_compare #(
      .NumWords (NumWords)
    ) i_compare (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .start_i      (start),
      .digest_i     (digest_i[r*RegionW +: RegionW]),
      .exp_digest_i (exp_digest_i[r*RegionW +: RegionW]),
      .result_o     (results[r])
    );
  end

  rom_check_collect #(
    .NumRegions (NumRegions)
  ) i_collect (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .results_i  (results),
    .ack_o      (ack_o),
    .good_o     (good_o),
    .fail_map_o (fail_map_o),
    .alert_o    (alert_o)
  );

endmodule

// ==== dv/tb_clkgen.sv ====
// ####################
// Clock and power-on reset for the testbench
// 100 ns period, reset held low for the first 10 cycles
// ####################

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ns;

  localparam int unsigned HalfPeriod  = 50;
  localparam int unsigned ResetCycles = 10;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (ResetCycles) @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #(HalfPeriod) clk_o = ~clk_o;

endmodule

// ==== dv/rom_check_checker.sv ====
// ####################
// Handshake and protocol assertions for the ROM checker
// Bound to rom_check_top from the testbench
// ####################

module rom_check_checker
  import rom_check_pkg::*;
(
  input logic   clk_i,
  input logic   rst_ni,
  input logic   req_i,
  input logic   ack_i,
  input mubi4_t good_i,
  input logic   alert_i
);

  timeunit 1ns;
  timeprecision 1ns;

  // Set once the first request after reset was answered
  logic acked_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acked_q <= 1'b0;
    end else if (ack_i) begin
      acked_q <= 1'b1;
    end
  end

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack rose without an open request");

  // Ack is released only after the requester withdraws
  ack_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i && req_i |=> ack_i)
    else $error("ack fell while req was still high");

  good_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    good_i == MuBi4True || good_i == MuBi4False)
    else $error("good is not a legal multi-bit value");

  no_early_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !acked_q |-> !alert_i)
    else $error("alert raised during the first request after reset");

endmodule

// ==== dv/tb_rom_check.sv ====
// ####################
// Testbench for the ROM integrity checker
// Loads digest vectors from a data file, adds LCG vectors,
// runs each through the four-phase handshake and checks
// verdict, fail map, alert and ack timing
// ####################

module tb_rom_check
  import rom_check_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int NumRegions = 4;
  localparam int NumWords   = 4;
  localparam int DigW       = NumRegions * NumWords * WordW;
  // Computed words, expected words, fail map
  localparam int VecWords   = 2 * NumRegions * NumWords + 1;
  localparam int MaxVec     = 32;
  localparam int RandVecs   = 20;
  localparam int AckLatency = NumWords + 3;
  localparam int AckLimit   = 4 * AckLatency;
  localparam string VecFile = "dv/rom_check_vectors.txt";

  logic clk;
  logic por_n;
  logic vec_rst_n;
  logic req;
  logic [DigW-1:0] digest;
  logic [DigW-1:0] exp_digest;
  logic ack;
  mubi4_t good;
  logic [NumRegions-1:0] fail_map;
  logic alert;

  logic [WordW-1:0] raw_mem [MaxVec*VecWords];
  logic [DigW-1:0] dig_mem [MaxVec];
  logic [DigW-1:0] exp_mem [MaxVec];
  logic [NumRegions-1:0] file_map [MaxVec];
  int file_vecs;
  int total_vecs;
  logic loaded;
  int value_errors;
  int other_errors;
  logic [31:0] rng;

  tb_clkgen i_clkgen (
    .clk_o  (clk),
    .rst_no (por_n)
  );

  rom_check_top #(
    .NumRegions (NumRegions),
    .NumWords   (NumWords)
  ) i_dut (
    .clk_i        (clk),
    .rst_ni       (por_n & vec_rst_n),
    .req_i        (req),
    .ack_o        (ack),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .good_o       (good),
    .fail_map_o   (fail_map),
    .alert_o      (alert)
  );

  bind rom_check_top rom_check_checker i_checker (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .ack_i   (ack_o),
    .good_i  (good_o),
    .alert_i (alert_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // A region fails if any of its word pairs differ
  function automatic logic [NumRegions-1:0] region_mismatch_map(
    input logic [DigW-1:0] dig, input logic [DigW-1:0] expd);
    logic [NumRegions-1:0] map;
    map = '0;
    for (int r = 0; r < NumRegions; r++) begin
      for (int w = 0; w < NumWords; w++) begin
        if (dig[(r*NumWords+w)*WordW +: WordW] != expd[(r*NumWords+w)*WordW +: WordW]) begin
          map[r] = 1'b1;
        end
      end
    end
    return map;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] expv);
    assert (got === expv) else begin
      value_errors++;
      $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expv);
    end
  endtask

  // Counts falling edges until ack or AckLimit
  task automatic wait_for_ack(output int cycles);
    cycles = 0;
    while (!ack && cycles < AckLimit) begin
      @(negedge clk);
      cycles++;
    end
    assert (ack) else begin
      other_errors++;
      $display("ack_o did not rise within %0d cycles at %0t", AckLimit, $time);
    end
  endtask

  task automatic load_vectors();
    int base;
    // Filler has nonzero upper bits and never looks like a fail map
    for (int a = 0; a < MaxVec*VecWords; a++) begin
      raw_mem[a] = 32'hA5A5_0000 ^ a;
    end
    $readmemh(VecFile, raw_mem);
    file_vecs = 0;
    base = VecWords - 1;
    while (file_vecs < MaxVec - RandVecs && raw_mem[base][WordW-1:NumRegions] == '0) begin
      for (int i = 0; i < NumRegions*NumWords; i++) begin
        dig_mem[file_vecs][i*WordW +: WordW] = raw_mem[base - VecWords + 1 + i];
        exp_mem[file_vecs][i*WordW +: WordW] = raw_mem[base - NumRegions*NumWords + i];
      end
      file_map[file_vecs] = raw_mem[base][NumRegions-1:0];
      file_vecs++;
      base += VecWords;
    end
    assert (file_vecs > 0) else begin
      other_errors++;
      $display("No vectors could be read from %s", VecFile);
    end
    total_vecs = file_vecs + RandVecs;
  endtask

  // Expected digest is a copy of the computed one with up to 3 words flipped
  task automatic add_random_vectors();
    int flips;
    int idx;
    for (int v = file_vecs; v < total_vecs; v++) begin
      for (int i = 0; i < NumRegions*NumWords; i++) begin
        rng = lcg_next(rng);
        dig_mem[v][i*WordW +: WordW] = rng;
      end
      exp_mem[v] = dig_mem[v];
      rng = lcg_next(rng);
      flips = int'(rng[18:17]);
      for (int f = 0; f < flips; f++) begin
        rng = lcg_next(rng);
        idx = int'(rng[19:16]);
        rng = lcg_next(rng);
        exp_mem[v][idx*WordW +: WordW] = exp_mem[v][idx*WordW +: WordW] ^ (rng | 32'h1);
      end
    end
  endtask

  task automatic run_vector(input int v);
    int cycles;
    logic [NumRegions-1:0] calc_map;
    calc_map   = region_mismatch_map(dig_mem[v], exp_mem[v]);
    vec_rst_n  = 1'b0;
    req        = 1'b0;
    digest     = dig_mem[v];
    exp_digest = exp_mem[v];
    repeat (10) @(negedge clk);
    vec_rst_n = 1'b1;
    // Idle after reset
    repeat (2) begin
      @(negedge clk);
      check_value("ack_o", 32'(ack), 32'd0);
    end
    req = 1'b1;
    wait_for_ack(cycles);
    check_value("ack latency", 32'(cycles), 32'(AckLatency));
    check_value("fail_map_o", 32'(fail_map), 32'(calc_map));
    if (v < file_vecs) begin
      check_value("fail_map_o", 32'(fail_map), 32'(file_map[v]));
    end
    check_value("good_o", 32'(good), 32'((calc_map == '0) ? MuBi4True : MuBi4False));
    check_value("alert_o", 32'(alert), 32'd0);
    req = 1'b0;
    @(negedge clk);
    check_value("ack_o", 32'(ack), 32'd0);
  endtask

  // Request again without reset while the comparators sit in Done
  task automatic second_request();
    int cycles;
    logic [NumRegions-1:0] last_map;
    // Verdict of the last vector must survive the extra request
    last_map = region_mismatch_map(dig_mem[total_vecs-1], exp_mem[total_vecs-1]);
    req = 1'b1;
    wait_for_ack(cycles);
    repeat (2) @(negedge clk);
    check_value("alert_o", 32'(alert), 32'd1);
    check_value("good_o", 32'(good), 32'((last_map == '0) ? MuBi4True : MuBi4False));
    check_value("fail_map_o", 32'(fail_map), 32'(last_map));
    req = 1'b0;
    @(negedge clk);
    check_value("ack_o", 32'(ack), 32'd0);
  endtask

  initial begin
    req          = 1'b0;
    digest       = '0;
    exp_digest   = '0;
    vec_rst_n    = 1'b1;
    loaded       = 1'b0;
    value_errors = 0;
    other_errors = 0;
    rng          = 32'd16;
    load_vectors();
    add_random_vectors();
    loaded = 1'b1;
    @(posedge por_n);
    @(negedge clk);
    for (int v = 0; v < total_vecs; v++) begin
      run_vector(v);
    end
    second_request();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the number of vectors
  initial begin
    wait (loaded);
    repeat (total_vecs * 40 + 100) @(posedge clk);
    $display("Watchdog expired after %0d cycles", total_vecs * 40 + 100);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== dv/rom_check_vectors.txt ====
// Per line: 16 computed digest words, 16 expected digest words, expected fail map
// Words run from region 0 word 0 upward, four words per region
c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007 c0de0008 c0de0009 c0de000a c0de000b c0de000c c0de000d c0de000e c0de000f c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007 c0de0008 c0de0009 c0de000a c0de000b c0de000c c0de000d c0de000e c0de000f 0
12340000 12340001 12340002 12340003 12340004 12340005 12340006 12340007 12340008 12340009 1234000a 1234000b 1234000c 1234000d 1234000e 1234000f 12340000 12340001 12340002 12340003 92340004 12340005 12340006 12340007 12340008 12340009 1234000a 1234000b 1234000c 1234000d 1234000e 1234000f 2
5a5a0000 5a5a0001 5a5a0002 5a5a0003 5a5a0004 5a5a0005 5a5a0006 5a5a0007 5a5a0008 5a5a0009 5a5a000a 5a5a000b 5a5a000c 5a5a000d 5a5a000e 5a5a000f 5a5a0000 5a5a0001 5a5a0002 5a5a0003 5a5a0004 5a5a0005 5a5a0006 5a5a0007 5a5a0008 5a5a0009 5a5a000a 5a5a000b 5a5a000c 5a5a000d 5a5a000e 5a5a800f 8
0bad0000 0bad0001 0bad0002 0bad0003 0bad0004 0bad0005 0bad0006 0bad0007 0bad0008 0bad0009 0bad000a 0bad000b 0bad000c 0bad000d 0bad000e 0bad000f 0bad0000 0bad0001 0bad0002 0bad0013 0bad0004 0bad0005 0bad0006 0bad0007 1bad0008 0bad0009 0bad000a 0bad000b 0bad000c 0bad000d 0bad000e 0bad000f 5
ffff0000 ffff0001 ffff0002 ffff0003 ffff0004 ffff0005 ffff0006 ffff0007 ffff0008 ffff0009 ffff000a ffff000b ffff000c ffff000d ffff000e ffff000f ffff0000 fffe0001 ffff0002 ffff0003 ffff0004 ffff0005 7fff0006 ffff0007 ffff0008 ffff0009 ffff00fa ffff000b ffff000c efff000d ffff000e ffff000f f

// ==== project.f ====
rtl/rom_check_pkg.sv
rtl/rom_check_dispatch.sv
rtl/rom_check_compare.sv
rtl/rom_check_collect.sv
rtl/rom_check_top.sv
dv/tb_clkgen.sv
dv/rom_check_checker.sv
dv/tb_rom_check.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_rom_check
FILELIST := project.f
OBJDIR   := obj_dir
LOG      := sim.log
FAIL_MSG := Result: FAILED
PASS_MSG := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
